/* test/sha3_stimulus.txt */
# name sel sel_after_start msg_len message(hex, - empty, * byte i = 7i+49) digest(hex, - none) ;
# digests are the FIPS 202 values, long ones split over two lines
empty_224 0 0 0 - 6b4e03423667dbb73b6e15454f0eb1abd4597f9a1b078e3f5b5a6bc7 ;
empty_256 1 1 0 - a7ffc6f8bf1ed76651c14756a061d662f580ff4de43b49fa82d80a4b80f8434a ;
empty_384 2 2 0 -
  0c63a75b845e4f7d01107d852e4c2485c51a50aaaa94fc61
  995e71bbee983a2ac3713831264adb47fb6bd1e058d5f004 ;
empty_512 3 3 0 -
  a69f73cca23a9ac5c8b567dc185a756e97c982164fe25859e0d1dcc1475c80a6
  15b2123af1f5f94c11e3e9402c3ac558f500199d95b6d3e301758586281dcd26 ;
# sel changed to a different mode once the hash has started
abc_224 0 3 3 616263 e642824c3f8cf24ad09234ee7d3c766fc9a3a5168d0c94ad73b46fdf ;
abc_256 1 2 3 616263 3a985da74fe225b2045c172d6bd390bd855f086e3e9d525b46bfe24511431532 ;
abc_384 2 0 3 616263
  ec01498288516fc926459f58e2c6ad8df9b473cb0fc08c25
  96da7cf0e49be4b298d88cea927ac7f539f1edf228376d25 ;
abc_512 3 1 3 616263
  b751850b1a57168a5693cd924b6b096e08f621827444f70d884f5d0240d2712e
  10e116e9192af3c91a7ec57647e3934057340b4cf408d5a56592f8274eec53f0 ;
# rate-1 messages, merged 0x86 pad byte checked in the block
max_256 1 3 135 * - ;
max_512 3 0 71 * - ;

/* files.f */
src/sha3_pkg.sv
src/sha3_mode_cfg.sv
src/sha3_ctrl.sv
src/sha3_absorb.sv
src/keccak_round.sv
src/keccak_core.sv
src/sha3_squeeze.sv
src/sha3_top.sv
test/sha3_sva.sv
test/tb_sha3.sv

/* test/tb_sha3.sv */
`timescale 1ns/1ps

module tb_sha3;
	import sha3_pkg::*;

	localparam int MAX_VEC = 16;
	localparam int STATE_BYTES = 200;
	// worst case per hash is largest rate, rounds, largest digest, idle gap and slack
	localparam int CYCLES_PER_VEC = 144 + 24 + 64 + 10;

	logic clk;
	logic reset_n;
	mode_sel_t sel;
	logic data_go;
	logic flag;
	byte_t in;
	logic in_go;
	logic out_go;
	byte_t out_value;

	// vectors as read from the stimulus file
	string vec_name [MAX_VEC];
	int vec_sel [MAX_VEC];
	int vec_sel_late [MAX_VEC];
	int vec_len [MAX_VEC];
	byte_t vec_msg [MAX_VEC][STATE_BYTES];
	byte_t vec_dig [MAX_VEC][64];
	int vec_dig_len [MAX_VEC];
	int num_vec;

	int cycles;
	int cycle_limit;

	sha3_top #(
		.MAX_DIGEST_BYTES(64)
	) i_dut (.*);

	always #50 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// failure handling and timeout
	////////////////////////////////////////////////////////////////////////////

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	// cycle limit and failures of the bound protocol checker
	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			fail_run("timeout: the DUT did not finish all vectors within the cycle limit");
		end else begin
			assert (i_dut.i_sva.fail_count == 0)
				else fail_run("a protocol assertion in sha3_sva failed");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// mode geometry from the SHA-3 mode table
	////////////////////////////////////////////////////////////////////////////

	function automatic int rate_for(int s);
		case (s)
			0: return 144;
			1: return 136;
			2: return 104;
			default: return 72;
		endcase
	endfunction

	function automatic int digest_len_for(int s);
		case (s)
			0: return 28;
			1: return 32;
			2: return 48;
			default: return 64;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// stimulus file parsing
	////////////////////////////////////////////////////////////////////////////

	// whitespace separated tokens
	// # starts a comment up to end of line
	function automatic string next_token(int fd);
		string tok;
		string rest;
		int n;
		tok = "";
		n = $fscanf(fd, "%s", tok);
		while (n == 1 && tok.getc(0) == "#") begin
			n = $fgets(rest, fd);
			n = $fscanf(fd, "%s", tok);
		end
		if (n != 1)
			tok = "";
		return tok;
	endfunction

	function automatic byte_t hex_byte(string s, int i);
		return byte_t'(s.substr(2*i, 2*i+1).atohex());
	endfunction

	task automatic load_vectors();
		int fd;
		string tok;
		fd = $fopen("test/sha3_stimulus.txt", "r");
		assert (fd != 0)
			else fail_run("could not open test/sha3_stimulus.txt");
		num_vec = 0;
		tok = next_token(fd);
		while (tok != "" && num_vec < MAX_VEC) begin
			vec_name[num_vec] = tok;
			tok = next_token(fd);
			vec_sel[num_vec] = tok.atoi();
			tok = next_token(fd);
			vec_sel_late[num_vec] = tok.atoi();
			tok = next_token(fd);
			vec_len[num_vec] = tok.atoi();
			// message as hex bytes, or - when empty, or * for an index pattern
			tok = next_token(fd);
			for (int i = 0; i < vec_len[num_vec]; i++)
				vec_msg[num_vec][i] = (tok == "*") ? byte_t'(i * 7 + 49) : hex_byte(tok, i);
			// digest chunks up to the ; terminator
			vec_dig_len[num_vec] = 0;
			tok = next_token(fd);
			while (tok != ";" && tok != "") begin
				if (tok != "-") begin
					for (int i = 0; i < tok.len() / 2; i++) begin
						vec_dig[num_vec][vec_dig_len[num_vec]] = hex_byte(tok, i);
						vec_dig_len[num_vec]++;
					end
				end
				tok = next_token(fd);
			end
			num_vec++;
			tok = next_token(fd);
		end
		$fclose(fd);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	// padded block is message, 0x06, zeros and 0x80 on the last rate byte
	// capacity bytes stay zero
	task automatic check_block(input int v, input int rate);
		byte_t exp_b;
		byte_t act_b;
		for (int k = 0; k < STATE_BYTES; k++) begin
			if (k < vec_len[v])
				exp_b = vec_msg[v][k];
			else if (k == vec_len[v])
				exp_b = 8'h06;
			else
				exp_b = 8'h00;
			if (k == rate - 1)
				exp_b = exp_b | 8'h80;
			if (k >= rate)
				exp_b = 8'h00;
			act_b = i_dut.block[8*k +: 8];
			assert (act_b == exp_b)
				else fail_run($sformatf("** Error: %s block byte %0d expected %02h actual %02h",
					vec_name[v], k, exp_b, act_b));
		end
	endtask

	task automatic run_vector(input int v);
		int rate;
		int dig_len;
		int sent;
		int got;
		logic seen_out;
		logic done;
		rate = rate_for(vec_sel[v]);
		dig_len = digest_len_for(vec_sel[v]);
		sent = 0;
		got = 0;
		seen_out = 1'b0;
		done = 1'b0;
		assert (vec_dig_len[v] == 0 || vec_dig_len[v] == dig_len)
			else fail_run($sformatf("%s: digest in the stimulus file has the wrong length",
				vec_name[v]));
		// idle gap with nothing requested before data_go
		repeat (3) begin
			@(negedge clk);
			assert (!in_go && !out_go)
				else fail_run($sformatf("%s: in_go or out_go high while idle", vec_name[v]));
		end
		sel = mode_sel_t'(vec_sel[v]);
		data_go = 1'b1;
		flag = 1'b1;
		@(negedge clk);
		data_go = 1'b0;
		// mode already latched so a wrong sel from here on must not matter
		sel = mode_sel_t'(vec_sel_late[v]);
		while (!done) begin
			if (in_go) begin
				// at most rate-1 message bytes are ever requested
				assert (sent < rate - 1)
					else fail_run($sformatf("%s: in_go still high after rate-1 bytes",
						vec_name[v]));
				if (sent < vec_len[v]) begin
					in = vec_msg[v][sent];
					flag = 1'b1;
					sent++;
				end else begin
					// message end marker
					in = 8'h00;
					flag = 1'b0;
				end
			end
			if (i_dut.block_done)
				check_block(v, rate);
			if (out_go) begin
				if (vec_dig_len[v] > 0)
					assert (out_value == vec_dig[v][got])
						else fail_run($sformatf("** Error: %s digest byte %0d expected %02h actual %02h",
							vec_name[v], got, vec_dig[v][got], out_value));
				got++;
				seen_out = 1'b1;
			end else if (seen_out) begin
				done = 1'b1;
			end
			if (!done)
				@(negedge clk);
		end
		assert (sent == vec_len[v])
			else fail_run($sformatf("** Error: %s message bytes taken expected %0d actual %0d",
				vec_name[v], vec_len[v], sent));
		assert (got == dig_len)
			else fail_run($sformatf("** Error: %s out_go cycles expected %0d actual %0d",
				vec_name[v], dig_len, got));
		flag = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		reset_n = 1'b0;
		sel = '0;
		data_go = 1'b0;
		flag = 1'b0;
		in = '0;
		cycles = 0;
		cycle_limit = 0;
		load_vectors();
		assert (num_vec > 0)
			else fail_run("no vectors found in test/sha3_stimulus.txt");
		// reset plus per-vector worst case
		cycle_limit = num_vec * CYCLES_PER_VEC + 16;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;
		for (int v = 0; v < num_vec; v++)
			run_vector(v);
		if (i_dut.i_sva.fail_count == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			fail_run("a protocol assertion in sha3_sva failed");
		end
	end

endmodule

/* test/sha3_sva.sv */
`timescale 1ns/1ps

module sha3_sva (
	input logic             clk,
	input logic             reset_n,
	input logic             in_go,
	input logic             out_go,
	input sha3_pkg::phase_t phase
);
	import sha3_pkg::*;

	// number of failed assertions so far
	int fail_count = 0;

	// absorb and squeeze never overlap
	assert property (@(posedge clk) disable iff (!reset_n)
		!(in_go && out_go))
		else begin
			$error("in_go and out_go high in the same cycle");
			fail_count++;
		end

	// digest stream opens only on squeeze entry
	assert property (@(posedge clk) disable iff (!reset_n)
		$rose(out_go) |-> (phase == PH_SQUEEZE))
		else begin
			$error("out_go rose outside the squeeze phase");
			fail_count++;
		end

	// closes only with the return to idle so a digest has no gaps
	assert property (@(posedge clk) disable iff (!reset_n)
		$fell(out_go) |-> (phase == PH_IDLE))
		else begin
			$error("out_go fell before the digest was complete");
			fail_count++;
		end

	// both strobes quiet in reset
	assert property (@(posedge clk)
		!reset_n |-> (!in_go && !out_go))
		else begin
			$error("in_go or out_go high during reset");
			fail_count++;
		end

endmodule

bind sha3_top sha3_sva i_sva (
	.clk(clk),
	.reset_n(reset_n),
	.in_go(in_go),
	.out_go(out_go),
	.phase(phase)
);

/* src/sha3_top.sv */
`timescale 1ns/1ps

module sha3_top #(
	parameter int MAX_DIGEST_BYTES = 64
) (
	input  logic                clk,
	input  logic                reset_n,
	input  sha3_pkg::mode_sel_t sel,
	input  logic                data_go,
	input  logic                flag,
	input  sha3_pkg::byte_t     in,
	output logic                in_go,
	output logic                out_go,
	output sha3_pkg::byte_t     out_value
);
	import sha3_pkg::*;

	logic start;
	logic squeeze_start;
	logic block_done;
	logic perm_done;
	logic squeeze_done;
	phase_t phase;
	mode_cfg_t cfg;
	state_t block;
	state_t state;

	////////////////////////////////////////////////////////////////////////////
	// control and mode
	////////////////////////////////////////////////////////////////////////////

	sha3_ctrl i_ctrl (.*);

	sha3_mode_cfg i_mode_cfg (.*);

	////////////////////////////////////////////////////////////////////////////
	// datapath
	////////////////////////////////////////////////////////////////////////////

	sha3_absorb i_absorb (.*);

	// permutation starts from the finished block
	keccak_core i_core (
		.load(block_done),
		.*
	);

	sha3_squeeze #(
		.MAX_DIGEST_BYTES(MAX_DIGEST_BYTES)
	) i_squeeze (.*);

endmodule

/* src/sha3_squeeze.sv */
`timescale 1ns/1ps

module sha3_squeeze #(
	parameter int MAX_DIGEST_BYTES = 64
) (
	input  logic                clk,
	input  logic                reset_n,
	input  logic                squeeze_start,
	input  sha3_pkg::mode_cfg_t cfg,
	input  sha3_pkg::state_t    state,
	output logic                out_go,
	output sha3_pkg::byte_t     out_value,
	output logic                squeeze_done
);
	import sha3_pkg::*;

	logic active;
	byte_cnt_t cnt;
	logic last;
	// digest bytes always come from the low end of the state
	logic [8*MAX_DIGEST_BYTES-1:0] digest;

	assign digest = state[8*MAX_DIGEST_BYTES-1:0];

	// stop at the mode length, or at the build limit
	assign last = (cnt == cfg.digest_bytes - 8'd1)
		|| (cnt == byte_cnt_t'(MAX_DIGEST_BYTES - 1));

	// out_go and squeeze_done lag active by one, in line with out_value
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			active <= 1'b0;
			cnt <= '0;
			out_go <= 1'b0;
			squeeze_done <= 1'b0;
		end else begin
			out_go <= active;
			squeeze_done <= active && last;
			if (squeeze_start) begin
				active <= 1'b1;
				cnt <= '0;
			end else if (active) begin
				cnt <= cnt + 8'd1;
				if (last)
					active <= 1'b0;
			end
		end
	end

	// lane 0 byte 0 first, lanes in index order
	always_ff @(posedge clk) begin
		if (active)
			out_value <= digest[8*cnt +: 8];
	end

endmodule

/* src/keccak_core.sv */
`timescale 1ns/1ps

module keccak_core (
	input  logic             clk,
	input  logic             reset_n,
	input  logic             load,
	input  sha3_pkg::state_t block,
	output sha3_pkg::state_t state,
	output logic             perm_done
);
	import sha3_pkg::*;

	logic running;
	round_t round;
	logic last_round;
	lane_t rc;
	state_t round_out;

	assign last_round = (round == round_t'(NUM_ROUNDS - 1));
	assign rc = round_constant(round);

	keccak_round i_round (
		.state_in(state),
		.rc(rc),
		.state_out(round_out)
	);

	// one round per clock
	// perm_done 24 cycles after load
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			running <= 1'b0;
			round <= '0;
			perm_done <= 1'b0;
		end else begin
			perm_done <= running && last_round;
			if (load) begin
				running <= 1'b1;
				round <= '0;
			end else if (running) begin
				round <= round + 5'd1;
				if (last_round)
					running <= 1'b0;
			end
		end
	end

	// single block message, so the state starts from the block itself
	always_ff @(posedge clk) begin
		if (load)
			state <= block;
		else if (running)
			state <= round_out;
	end

endmodule

/* src/keccak_round.sv */
`timescale 1ns/1ps

module keccak_round (
	input  sha3_pkg::state_t state_in,
	input  sha3_pkg::lane_t  rc,
	output sha3_pkg::state_t state_out
);
	import sha3_pkg::*;

	// rho offsets, indexed x+5y
	localparam int RHO [25] = '{
		0, 1, 62, 28, 27,
		36, 44, 6, 55, 20,
		3, 10, 43, 25, 39,
		41, 45, 15, 21, 8,
		18, 2, 61, 56, 14
	};

	lane_t a [25];
	lane_t b [25];
	lane_t c [5];
	lane_t d [5];

	function automatic lane_t rotl(lane_t v, int n);
		return (v << n) | (v >> ((64 - n) % 64));
	endfunction

	always_comb begin
		for (int i = 0; i < 25; i++)
			a[i] = state_in[64*i +: 64];

		// theta, column parity
		for (int x = 0; x < 5; x++)
			c[x] = a[x] ^ a[x+5] ^ a[x+10] ^ a[x+15] ^ a[x+20];
		for (int x = 0; x < 5; x++)
			d[x] = c[(x+4)%5] ^ rotl(c[(x+1)%5], 1);

		// theta xor, rho rotate, pi moves (x,y) to (y, 2x+3y)
		for (int x = 0; x < 5; x++)
			for (int y = 0; y < 5; y++)
				b[y + 5*((2*x + 3*y) % 5)] = rotl(a[x + 5*y] ^ d[x], RHO[x + 5*y]);

		// chi along each row
		// iota only into lane 0
		for (int x = 0; x < 5; x++)
			for (int y = 0; y < 5; y++)
				state_out[64*(x + 5*y) +: 64] = b[x + 5*y]
					^ (~b[(x+1)%5 + 5*y] & b[(x+2)%5 + 5*y])
					^ ((x + 5*y == 0) ? rc : lane_t'(0));
	end

endmodule

/* src/sha3_absorb.sv */
`timescale 1ns/1ps

module sha3_absorb (
	input  logic                clk,
	input  logic                reset_n,
	input  logic                start,
	input  sha3_pkg::mode_cfg_t cfg,
	input  logic                flag,
	input  sha3_pkg::byte_t     in,
	output logic                in_go,
	output sha3_pkg::state_t    block,
	output logic                block_done
);
	import sha3_pkg::*;

	logic active;
	// still inside the message, first pad byte not yet written
	logic in_msg;
	byte_cnt_t cnt;
	logic last;
	logic accept;
	byte_t pad_byte;
	byte_t byte_val;

	// last byte of the rate
	assign last = (cnt == cfg.rate_bytes - 8'd1);

	// never ask for a byte in the last slot, max message is rate-1
	assign in_go = active && in_msg && !last;
	assign accept = in_go && flag;

	// 0x06 on message end, 0x80 on last slot, both give 0x86
	assign pad_byte = (in_msg ? 8'h06 : 8'h00) | (last ? 8'h80 : 8'h00);
	assign byte_val = accept ? in : pad_byte;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			active <= 1'b0;
			in_msg <= 1'b0;
			cnt <= '0;
			block_done <= 1'b0;
		end else begin
			block_done <= active && last;
			if (start) begin
				active <= 1'b1;
				in_msg <= 1'b1;
				cnt <= '0;
			end else if (active) begin
				// message ends on the first slot without an accepted byte
				in_msg <= accept;
				cnt <= cnt + 8'd1;
				if (last)
					active <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// block assembly, byte cnt at bits [8*cnt +: 8]
	////////////////////////////////////////////////////////////////////////////

	// capacity lanes stay zero from the clear on start
	always_ff @(posedge clk) begin
		if (start)
			block <= '0;
		else if (active)
			block[8*cnt +: 8] <= byte_val;
	end

endmodule

/* src/sha3_ctrl.sv */
`timescale 1ns/1ps

module sha3_ctrl (
	input  logic             clk,
	input  logic             reset_n,
	input  logic             data_go,
	input  logic             flag,
	input  logic             block_done,
	input  logic             perm_done,
	input  logic             squeeze_done,
	output logic             start,
	output logic             squeeze_start,
	output sha3_pkg::phase_t phase
);
	import sha3_pkg::*;

	phase_t phase_nxt;

	// new hash only from idle, data_go while busy is dropped
	assign start = (phase == PH_IDLE) && data_go && flag;
	assign squeeze_start = (phase == PH_PERMUTE) && perm_done;

	////////////////////////////////////////////////////////////////////////////
	// phase sequencing
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		phase_nxt = phase;
		case (phase)
			PH_IDLE: phase_nxt = start ? PH_ABSORB : PH_IDLE;
			// whole rate incl. padding collected
			PH_ABSORB: phase_nxt = block_done ? PH_PERMUTE : PH_ABSORB;
			// 24 rounds finished
			PH_PERMUTE: phase_nxt = perm_done ? PH_SQUEEZE : PH_PERMUTE;
			// last digest byte on out_value
			PH_SQUEEZE: phase_nxt = squeeze_done ? PH_IDLE : PH_SQUEEZE;
			default: phase_nxt = PH_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			phase <= PH_IDLE;
		end else begin
			phase <= phase_nxt;
		end
	end

endmodule

/* src/sha3_mode_cfg.sv */
`timescale 1ns/1ps

module sha3_mode_cfg (
	input  logic                clk,
	input  logic                reset_n,
	input  logic                start,
	input  sha3_pkg::mode_sel_t sel,
	output sha3_pkg::mode_cfg_t cfg
);
	import sha3_pkg::*;

	// sel sampled once per hash
	// later changes of sel are ignored until the next start
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			cfg <= mode_table('0);
		end else if (start) begin
			cfg <= mode_table(sel);
		end
	end

endmodule

/* src/sha3_pkg.sv */
package sha3_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////////////////////

	typedef logic [63:0] lane_t;
	typedef logic [7:0] byte_t;
	// 25 lanes, lane x+5y at bits [64*(x+5y) +: 64]
	typedef logic [1599:0] state_t;
	typedef logic [4:0] round_t;
	typedef logic [7:0] byte_cnt_t;
	typedef logic [1:0] mode_sel_t;

	localparam int NUM_ROUNDS = 24;

	typedef struct packed {
		byte_cnt_t rate_bytes;
		byte_cnt_t digest_bytes;
	} mode_cfg_t;

	typedef enum logic [1:0] {
		PH_IDLE,
		PH_ABSORB,
		PH_PERMUTE,
		PH_SQUEEZE
	} phase_t;

	// sel 0..3 maps to sha3-224 / 256 / 384 / 512
	function automatic mode_cfg_t mode_table(mode_sel_t sel);
		mode_cfg_t cfg;
		case (sel)
			2'd0: cfg = '{rate_bytes: 8'd144, digest_bytes: 8'd28};
			2'd1: cfg = '{rate_bytes: 8'd136, digest_bytes: 8'd32};
			2'd2: cfg = '{rate_bytes: 8'd104, digest_bytes: 8'd48};
			default: cfg = '{rate_bytes: 8'd72, digest_bytes: 8'd64};
		endcase
		return cfg;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// iota constants
	////////////////////////////////////////////////////////////////////////////

	// only bits 0,1,3,7,15,31,63 are ever set, so 8 bits per round suffice
	function automatic lane_t round_constant(round_t r);
		byte_t c;
		case (r)
			5'd0: c = 8'h01;
			5'd1: c = 8'h32;
			5'd2: c = 8'hBA;
			5'd3: c = 8'hE0;
			5'd4: c = 8'h3B;
			5'd5: c = 8'h41;
			5'd6: c = 8'hF1;
			5'd7: c = 8'hA9;
			5'd8: c = 8'h1A;
			5'd9: c = 8'h18;
			5'd10: c = 8'h69;
			5'd11: c = 8'h4A;
			5'd12: c = 8'h7B;
			5'd13: c = 8'h9B;
			5'd14: c = 8'hB9;
			5'd15: c = 8'hA3;
			5'd16: c = 8'hA2;
			5'd17: c = 8'h90;
			5'd18: c = 8'h2A;
			5'd19: c = 8'hCA;
			5'd20: c = 8'hF1;
			5'd21: c = 8'hB0;
			5'd22: c = 8'h41;
			5'd23: c = 8'hE8;
			default: c = 8'h00;
		endcase
		// spread back out to bit positions 63, 31, 15, 7, 3..0
		return {c[7], 31'd0, c[6], 15'd0, c[5], 7'd0, c[4], 3'd0, c[3:0]};
	endfunction

endpackage
